/* sim.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_control.sv
verilog/icache_stage_reg.sv
verilog/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

/* testbench/icache_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_mem_model
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       mem_read,
  input  addr_t      mem_addr,
  input  logic [2:0] delay,
  output logic       mem_resp,
  output line_t      mem_rdata
);

  logic       busy;
  logic [2:0] wait_cnt;
  addr_t      line_addr;
  logic       rst_s;
  logic       read_s;
  addr_t      addr_s;
  logic [2:0] delay_s;

  // every address bit feeds the word.
  function automatic word_t word_at(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic line_t line_at(addr_t base);
    line_t l;
    for (int k = 0; k < `ICACHE_LINE_W / 32; k++) begin
      l[32*k +: 32] = word_at(base + 4 * k);
    end
    return l;
  endfunction

  initial begin
    busy      = 1'b0;
    wait_cnt  = '0;
    mem_resp  = 1'b0;
    mem_rdata = '0;
  end

  always begin
    @(negedge clk);  // sample mid-cycle.
    rst_s   = rst;
    read_s  = mem_read;
    addr_s  = mem_addr;
    delay_s = delay;
    @(posedge clk);
    #2;
    if (rst_s) begin
      busy     = 1'b0;
      mem_resp = 1'b0;
    end else if (mem_resp) begin
      mem_resp  = 1'b0;  // one-cycle response.
      mem_rdata = '0;
    end else if (busy) begin
      if (wait_cnt == 0) begin
        busy      = 1'b0;
        mem_resp  = 1'b1;
        mem_rdata = line_at(line_addr);
      end else begin
        wait_cnt = wait_cnt - 1'b1;
      end
    end else if (read_s) begin
      busy      = 1'b1;
      wait_cnt  = delay_s;  // latency of 1 to 8 cycles.
      line_addr = addr_s;
    end
  end

endmodule

`default_nettype wire

/* testbench/icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int N_RAND   = 60;
  localparam int N_REQ    = 42 + N_RAND;  // directed plus random.
  localparam int WATCHDOG = N_REQ * 20 + 200;

  logic       clk, rst;
  logic       req_valid, req_ready;
  fetch_req_t req;
  logic       resp_valid, resp_ready;
  word_t      resp_data;
  logic       mem_read, mem_resp;
  addr_t      mem_addr;
  line_t      mem_rdata;
  logic [2:0] mem_delay;

  logic [15:0] lfsr;
  logic        stall_on, read_seen, miss_open;
  addr_t       rand_addr [N_RAND];
  word_t       exp_q [$];
  addr_t       miss_q [$];
  int          word_errs, addr_errs, read_errs, other_errs;

  // reference cache state.
  bit    ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
  tag_t  ref_tag [`ICACHE_SETS][`ICACHE_WAYS];
  plru_t ref_plru [`ICACHE_SETS];

  icache_top dut0 (
    .clk, .rst,
    .req_valid, .req_ready, .req,
    .resp_valid, .resp_ready, .resp_data,
    .mem_read, .mem_addr, .mem_resp, .mem_rdata
  );

  icache_mem_model mem0 (
    .clk, .rst, .mem_read, .mem_addr, .delay(mem_delay), .mem_resp, .mem_rdata
  );

  always #20 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 taps stepped once per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic word_t expected_word(addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]};
  endfunction

  function automatic int plru_victim(plru_t p);
    if (p[0]) begin
      return p[2] ? 3 : 2;
    end
    return p[1] ? 1 : 0;
  endfunction

  function automatic plru_t plru_touch(plru_t p, int way);
    plru_t n;
    n = p;
    n[0] = (way < 2);
    if (way < 2) begin
      n[1] = (way == 0);
    end else begin
      n[2] = (way == 2);
    end
    return n;
  endfunction

  // returns 1 on a miss.
  function automatic bit model_access(addr_t a);
    index_t idx;
    tag_t   t;
    int     way;
    idx = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    t   = a[31 -: `ICACHE_TAG_W];
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == t) begin
        way = w;
      end
    end
    if (way >= 0) begin
      ref_plru[idx] = plru_touch(ref_plru[idx], way);
      return 1'b0;
    end
    way = plru_victim(ref_plru[idx]);
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!ref_valid[idx][w]) begin
        way = w;  // lowest empty way.
      end
    end
    ref_valid[idx][way] = 1'b1;
    ref_tag[idx][way]   = t;
    ref_plru[idx]       = plru_touch(ref_plru[idx], way);
    return 1'b1;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      addr_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task report_counts;
    $display("errors: data %0d, address %0d, unexpected reads %0d, other %0d",
             word_errs, addr_errs, read_errs, other_errs);
  endtask

  task automatic fetch(input addr_t a);
    req_valid = 1'b1;
    req.addr  = a;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  always begin
    @(posedge clk);
    #2;
    resp_ready = stall_on ? (rand_bits(2) != 0) : 1'b1;  // stalls one cycle in four.
    mem_delay  = 3'(rand_bits(3));
  end

  // handshakes are stable mid-cycle and complete at the next edge.
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (resp_valid && !resp_ready && req_ready) begin
        other_errs++;
        $display("request channel ready while a response is held at %0t", $time);
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("response delivered with no request outstanding at %0t", $time);
        end else begin
          check_word("resp_data", resp_data, exp_q.pop_front());
          if (exp_q.size() == 0) begin
            miss_open = 1'b0;
          end
        end
      end
      if (req_valid && req_ready) begin
        if (miss_open) begin
          other_errs++;
          $display("request accepted before the missed word came back at %0t", $time);
        end
        if (model_access(req.addr)) begin
          miss_open = 1'b1;
          miss_q.push_back(req.addr - req.addr % 32);
        end
        exp_q.push_back(expected_word(req.addr));
      end
      if (mem_read && !read_seen) begin
        if (miss_q.size() == 0) begin
          read_errs++;
          $display("memory read of %h without a predicted miss at %0t", mem_addr, $time);
        end else begin
          check_addr("mem_addr", mem_addr, miss_q.pop_front());
        end
      end
      read_seen = mem_read;
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout after %0d cycles with requests still outstanding", WATCHDOG);
    report_counts();
    $display("Verification failed");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b1;
    mem_delay  = '0;
    stall_on   = 1'b0;
    read_seen  = 1'b0;
    miss_open  = 1'b0;
    lfsr       = 16'd60156;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      ref_plru[s] = '0;
    end
    for (int i = 0; i < N_RAND; i++) begin
      rand_addr[i] = 32'h0002_0000 | (rand_bits(9) << 2);  // word, set and tag bits.
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // cold lines miss once each.
    for (int i = 0; i < 12; i++) begin
      fetch(32'h0000_1000 + 32 * i + 4 * (i % 8));
    end
    for (int k = 0; k < 8; k++) begin
      fetch(32'h0000_1000 + 4 * k);  // back-to-back hits.
    end
    for (int i = 0; i < 12; i++) begin
      fetch(32'h0000_1000 + 32 * i + 4 * ((i + 3) % 8));
    end
    // five tags in set 5 force an eviction.
    for (int j = 0; j < 5; j++) begin
      fetch(32'h0004_00a0 + 256 * j);
    end
    for (int j = 4; j >= 0; j--) begin
      fetch(32'h0004_00a4 + 256 * j);
    end

    @(negedge clk);
    stall_on = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < N_RAND; i++) begin
      fetch(rand_addr[i]);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    if (miss_q.size() != 0) begin
      other_errs++;
      $display("%0d predicted misses never read memory", miss_q.size());
    end
    report_counts();
    if (word_errs + addr_errs + read_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// byte offset within a 32-byte line.
`define ICACHE_OFFSET_W 5

// set index, eight sets.
`define ICACHE_INDEX_W 3

// 32 - offset - index.
`define ICACHE_TAG_W 24

`define ICACHE_WAYS 4

`define ICACHE_SETS 8

// one full line as returned by memory.
`define ICACHE_LINE_W 256

`endif

/* verilog/icache_control.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_control
  import icache_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  output logic req_ready,
  input  logic lookup_hit,
  input  logic stage_busy,
  input  logic mem_resp,
  output logic mem_read,
  output logic refill_load,
  output logic plru_load,
  output logic stage_load,
  output logic replay_sel
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_LOOKUP;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next  = state;
    req_ready   = 1'b0;
    mem_read    = 1'b0;
    refill_load = 1'b0;
    plru_load   = 1'b0;
    stage_load  = 1'b0;
    replay_sel  = 1'b0;
    unique case (state)
      ST_LOOKUP: begin
        req_ready = !stage_busy;
        if (req_valid && !stage_busy) begin
          if (lookup_hit) begin
            stage_load = 1'b1;
            plru_load  = 1'b1;
          end else begin
            // miss entry is dropped, replayed later.
            state_next = ST_REFILL;
          end
        end
      end
      ST_REFILL: begin
        replay_sel = 1'b1;      // index the held miss address.
        mem_read   = 1'b1;
        if (mem_resp) begin
          refill_load = 1'b1;
          state_next  = ST_REPLAY;
        end
      end
      ST_REPLAY: begin
        replay_sel = 1'b1;
        // previous word may still be waiting on the consumer
        if (!stage_busy) begin
          stage_load = 1'b1;
          plru_load  = 1'b1;
          state_next = ST_LOOKUP;
        end
      end
      default: begin
        state_next = ST_LOOKUP;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [`ICACHE_LINE_W-1:0] line_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WAYS-1:0] way_t;    // one-hot.

  // bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3.
  typedef logic [2:0] plru_t;

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // lookup result handed to stage 2.
  typedef struct packed {
    addr_t addr;
    logic  hit;
    line_t line;
  } stage_t;

  typedef enum logic [1:0] {
    ST_LOOKUP,
    ST_REFILL,
    ST_REPLAY
  } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/icache_stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_stage_reg
  import icache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   stage_load,
  input  stage_t in,
  output logic   stage_busy,
  output logic   resp_valid,
  input  logic   resp_ready,
  output word_t  resp_data
);

  stage_t held;
  logic   valid_q;
  logic [`ICACHE_OFFSET_W-3:0] word_sel;

  // a new load overrides the drain in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (stage_load) begin
      valid_q <= 1'b1;
    end else if (resp_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_load) begin
      held <= in;
    end
  end

  assign resp_valid = valid_q;
  assign stage_busy = valid_q && !resp_ready;  // full and not draining.

  // word within the line, byte bits dropped.
  assign word_sel  = held.addr[`ICACHE_OFFSET_W-1:2];
  assign resp_data = held.line[32*word_sel +: 32];

endmodule

`default_nettype wire

/* verilog/icache_tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_tag_store
  import icache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  addr_t  lookup_addr,
  input  logic   refill_load,
  input  line_t  refill_line,
  input  logic   plru_load,
  output stage_t result
);

  way_t  valid_q [`ICACHE_SETS];
  tag_t  tag_q   [`ICACHE_SETS][`ICACHE_WAYS];
  line_t data_q  [`ICACHE_SETS][`ICACHE_WAYS];
  plru_t plru_q  [`ICACHE_SETS];

  index_t idx;
  tag_t   tag;
  way_t   hit_way;
  way_t   plru_way;
  way_t   victim;
  line_t  hit_line;
  plru_t  plru_next;

  assign idx = lookup_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign tag = lookup_addr[`ICACHE_OFFSET_W + `ICACHE_INDEX_W +: `ICACHE_TAG_W];

  // compare all ways at once, hit vector is one-hot.
  always_comb begin
    hit_way = '0;
    hit_line = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_way[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
      hit_line = hit_line | ({`ICACHE_LINE_W{hit_way[w]}} & data_q[idx][w]);
    end
  end

  assign result.addr = lookup_addr;
  assign result.hit  = |hit_way;
  assign result.line = hit_line;

  // tree bits point toward the victim.
  always_comb begin
    plru_way = '0;
    if (plru_q[idx][0]) begin
      plru_way[3] = plru_q[idx][2];
      plru_way[2] = !plru_q[idx][2];
    end else begin
      plru_way[1] = plru_q[idx][1];
      plru_way[0] = !plru_q[idx][1];
    end
  end

  // lowest invalid way wins over the tree.
  always_comb begin
    victim = plru_way;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[idx][w]) begin
        victim = '0;
        victim[w] = 1'b1;
      end
    end
  end

  // point the tree away from the way just used.
  always_comb begin
    plru_next = plru_q[idx];
    if (hit_way[0] || hit_way[1]) begin
      plru_next[0] = 1'b1;
      plru_next[1] = hit_way[0];
    end else if (hit_way[2] || hit_way[3]) begin
      plru_next[0] = 1'b0;
      plru_next[2] = hit_way[2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
        plru_q[s]  <= '0;
      end
    end else begin
      if (refill_load) begin
        valid_q[idx] <= valid_q[idx] | victim;
      end
      if (plru_load) begin
        plru_q[idx] <= plru_next;
      end
    end
  end

  // line and tag go into the victim way only.
  always_ff @(posedge clk) begin
    if (refill_load) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (victim[w]) begin
          tag_q[idx][w]  <= tag;
          data_q[idx][w] <= refill_line;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  output logic       req_ready,
  input  fetch_req_t req,
  output logic       resp_valid,
  input  logic       resp_ready,
  output word_t      resp_data,
  output logic       mem_read,
  output addr_t      mem_addr,
  input  logic       mem_resp,
  input  line_t      mem_rdata
);

  addr_t  miss_addr;
  addr_t  lookup_addr;
  stage_t lookup_result;
  logic   refill_load;
  logic   plru_load;
  logic   stage_load;
  logic   replay_sel;
  logic   stage_busy;

  // last accepted address, replayed after a miss.
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      miss_addr <= req.addr;
    end
  end

  assign lookup_addr = replay_sel ? miss_addr : req.addr;
  assign mem_addr    = {miss_addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

  icache_tag_store tags (
    .clk,
    .rst,
    .lookup_addr,
    .refill_load,
    .refill_line (mem_rdata),
    .plru_load,
    .result      (lookup_result)
  );

  icache_control control (
    .clk,
    .rst,
    .req_valid,
    .req_ready,
    .lookup_hit  (lookup_result.hit),
    .stage_busy,
    .mem_resp,
    .mem_read,
    .refill_load,
    .plru_load,
    .stage_load,
    .replay_sel
  );

  icache_stage_reg stage (
    .clk,
    .rst,
    .stage_load,
    .in          (lookup_result),
    .stage_busy,
    .resp_valid,
    .resp_ready,
    .resp_data
  );

endmodule

`default_nettype wire
